// ==== tb.f ====
design/gamePkg.sv
design/objectIf.sv
design/apbRegs.sv
design/shotLogic.sv
design/targetLogic.sv
design/hitDetector.sv
design/shotGameTop.sv
dv/shotGameTb.sv

// ==== Bender.yml ====
package:
  name: shotGame

sources:
  - design/gamePkg.sv
  - design/objectIf.sv
  - design/apbRegs.sv
  - design/shotLogic.sv
  - design/targetLogic.sv
  - design/hitDetector.sv
  - design/shotGameTop.sv
  - target: test
    files:
      - dv/shotGameTb.sv

// ==== dv/shotGameTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module shotGameTb;

	logic clk = 1'b0;
	logic resetN = 1'b0;
	logic startOfFrame = 1'b0;
	logic psel = 1'b0;
	logic penable = 1'b0;
	logic pwrite = 1'b0;
	logic [3:0] paddr = '0;
	logic [31:0] pwdata = '0;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic signed [gamePkg::coordWidth-1:0] shotX;
	logic signed [gamePkg::coordWidth-1:0] shotY;
	logic shotActive;
	logic signed [gamePkg::coordWidth-1:0] targetX;
	logic signed [gamePkg::coordWidth-1:0] targetY;
	logic hit;

	// reference model, shot position in 1/64 pixel
	int mShotX = gamePkg::screenWidth << gamePkg::fixedShift;
	int mShotY = gamePkg::screenHeight << gamePkg::fixedShift;
	int mShotVx = 0;
	bit mShotOn = 1'b0;
	bit mPending = 1'b0;                 // fire command waiting for a free shot
	int mFireDir = 0;
	int mFireX = 0;
	int mTx = 0;
	int mTy = 40;
	int mVel = 2;
	int mSpeedSeen = 2;                  // host speed at the last frame
	int mSpeedReg = 2;                   // TARGET register contents
	int mRowReg = 40;
	int mScore = 0;
	int bounces = 0;

	int phase = 0;                       // clock count inside a 20 cycle frame
	int cycles = 0;
	int errors = 0;
	int errMark = 0;
	int tests = 0;
	integer seed = 32'h96db8ed3;
	// seven flights, four target crossings at speed 5, 20 cycles per frame, some margin
	int cycleLimit = (7 * (((gamePkg::launchY + gamePkg::spriteSize) << gamePkg::fixedShift)
		/ gamePkg::shotSpeedY + 2) + 4 * ((gamePkg::screenWidth - gamePkg::spriteSize) / 5 + 1)
		+ 100) * 20;

	shotGameTop u_dut (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.shotX(shotX),
		.shotY(shotY),
		.shotActive(shotActive),
		.targetX(targetX),
		.targetY(targetY),
		.hit(hit)
	);

	always #5 clk = ~clk;

	always @(posedge clk or negedge resetN) begin
		if (!resetN)
			phase <= 0;
		else
			phase <= (phase == 19) ? 0 : phase + 1;
	end

	always @(negedge clk)
		startOfFrame <= resetN && (phase == 19);   // frame edge is the 19 to 0 step

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("Finished with errors");
			$finish;
		end
	end

	// equal 32 pixel boxes, both active
	function automatic logic overlap();
		int dx;
		int dy;
		dx = (mShotX >>> gamePkg::fixedShift) - mTx;
		dy = (mShotY >>> gamePkg::fixedShift) - mTy;
		return mShotOn && (dx > -gamePkg::spriteSize) && (dx < gamePkg::spriteSize) &&
			(dy > -gamePkg::spriteSize) && (dy < gamePkg::spriteSize);
	endfunction

	// one frame of the game rules
	function automatic void refStep();
		logic coll;
		int vel;
		int nextX;
		coll = overlap();
		if (coll && mScore < 16'hFFFF)
			mScore++;
		if (coll || mShotY <= -(gamePkg::spriteSize << gamePkg::fixedShift)) begin
			mShotX = gamePkg::screenWidth << gamePkg::fixedShift;     // park
			mShotY = gamePkg::screenHeight << gamePkg::fixedShift;
			mShotOn = 1'b0;
		end else if (!mShotOn && mPending) begin
			mShotX = mFireX << gamePkg::fixedShift;
			mShotY = gamePkg::launchY << gamePkg::fixedShift;
			mShotVx = (mFireDir == 1) ? gamePkg::shotSpeedX :
				(mFireDir == 2) ? -gamePkg::shotSpeedX : 0;
			mShotOn = 1'b1;
			mPending = 1'b0;
		end else if (mShotOn) begin
			mShotX += mShotVx;
			mShotY -= gamePkg::shotSpeedY;    // upward
		end
		vel = (mSpeedReg != mSpeedSeen) ? mSpeedReg : mVel;   // new host speed reloads
		nextX = mTx + vel;
		mSpeedSeen = mSpeedReg;
		mTy = mRowReg;
		if (coll) begin
			mTx = 0;
			mVel = mSpeedReg;
		end else if (nextX < 0 || nextX > gamePkg::screenWidth - gamePkg::spriteSize) begin
			mTx = (nextX < 0) ? 0 : gamePkg::screenWidth - gamePkg::spriteSize;
			mVel = -vel;
			bounces++;
		end else begin
			mTx = nextX;
			mVel = vel;
		end
	endfunction

	task automatic checkVal(input string what, input logic signed [31:0] got,
		input logic signed [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// model steps on each frame edge, outputs compared half a cycle later
	always @(posedge clk) begin
		if (resetN && startOfFrame) begin
			refStep();
			@(negedge clk);
			checkVal("shot x", shotX, mShotX >>> gamePkg::fixedShift);
			checkVal("shot y", shotY, mShotY >>> gamePkg::fixedShift);
			checkVal("shot active", shotActive, mShotOn);
			checkVal("target x", targetX, mTx);
			checkVal("target y", targetY, mTy);
			checkVal("hit", hit, overlap());
		end
	end

	task automatic finishTest(input string name);
		tests++;
		$display("test %0d %s done, %0d errors", tests, name, errors - errMark);
		errMark = errors;
	endtask

	// setup and access never land on a frame edge
	task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err);
		@(negedge clk);
		while (phase > 17)
			@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		err = pslverr;                    // response is up for the whole access phase
		checkVal("write pready", pready, 1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk);
		while (phase > 17)
			@(negedge clk);
		psel = 1'b1;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		data = prdata;
		err = pslverr;
		checkVal("read pready", pready, 1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic fire(input int dir, input int x);
		logic err;
		apbWrite(gamePkg::addrFire, {19'd0, 2'(dir), 11'(x)}, err);
		checkVal("fire write pslverr", err, 0);
		mPending = 1'b1;
		mFireDir = dir;
		mFireX = x;
	endtask

	task automatic setTarget(input int speed, input int row);
		logic err;
		apbWrite(gamePkg::addrTarget, {16'd0, 6'(speed), 10'(row)}, err);
		checkVal("target write pslverr", err, 0);
		mSpeedReg = speed;
		mRowReg = row;
	endtask

	initial begin
		logic err;
		logic [31:0] rd;
		int x;
		int bounceStart;
		int scoreBefore;
		repeat (3) @(negedge clk);
		resetN = 1'b1;
		@(negedge clk);

		checkVal("reset shot x", shotX, 640);
		checkVal("reset shot y", shotY, 480);
		checkVal("reset shot active", shotActive, 0);
		checkVal("reset target x", targetX, 0);
		checkVal("reset target y", targetY, 40);
		checkVal("reset pready", pready, 1);
		checkVal("reset pslverr", pslverr, 0);
		apbRead(gamePkg::addrScore, rd, err);
		checkVal("reset score", rd, 0);
		checkVal("score read pslverr", err, 0);
		apbRead(gamePkg::addrStatus, rd, err);
		checkVal("reset status", rd, 0);
		finishTest("reset state");

		setTarget(2, 600);                   // row below the screen, out of the shot's way
		for (int dir = 0; dir < 4; dir++) begin
			x = 80 + ($random(seed) & 511);
			fire(dir, x);
			while (!shotActive)
				@(negedge clk);
			checkVal("launch x", shotX, x);
			checkVal("launch y", shotY, gamePkg::launchY);
			while (shotActive)
				@(negedge clk);
		end
		finishTest("flight");

		setTarget(5, 100);
		bounceStart = bounces;
		while (bounces < bounceStart + 3)
			@(negedge clk);
		checkVal("bounce row", targetY, 100);
		finishTest("target bounce");

		setTarget(0, 100);                   // target holds still at its model column
		scoreBefore = mScore;
		fire(0, mTx);
		while (!shotActive)
			@(negedge clk);
		while (shotActive)
			@(negedge clk);
		apbRead(gamePkg::addrScore, rd, err);
		checkVal("score after hit", rd, scoreBefore + 1);
		checkVal("respawn x", targetX, 0);
		checkVal("parked after hit", shotY, 480);
		finishTest("hit");

		setTarget(3, 600);
		x = 80 + ($random(seed) & 511);
		fire($random(seed) & 3, x);
		while (!shotActive)
			@(negedge clk);
		x = 80 + ($random(seed) & 511);
		fire($random(seed) & 3, x);          // shot busy, so this one waits
		apbRead(gamePkg::addrStatus, rd, err);
		checkVal("status in flight", rd, 3);
		while (shotActive)
			@(negedge clk);
		apbRead(gamePkg::addrStatus, rd, err);
		checkVal("status after flight", rd, 2);
		while (!shotActive)
			@(negedge clk);
		checkVal("pending launch x", shotX, x);
		apbRead(gamePkg::addrStatus, rd, err);
		checkVal("status after launch", rd, 1);
		while (shotActive)
			@(negedge clk);
		finishTest("pending fire");

		apbRead(4'h6, rd, err);
		checkVal("unused address pslverr", err, 1);
		apbWrite(gamePkg::addrScore, 32'h1234, err);
		checkVal("score write pslverr", err, 1);
		apbWrite(gamePkg::addrStatus, 32'h3, err);
		checkVal("status write pslverr", err, 1);
		apbRead(gamePkg::addrScore, rd, err);
		checkVal("score kept", rd, mScore);
		checkVal("score read pslverr", err, 0);
		apbRead(gamePkg::addrTarget, rd, err);
		checkVal("target kept", rd, {16'd0, 6'(mSpeedReg), 10'(mRowReg)});
		apbRead(gamePkg::addrStatus, rd, err);
		checkVal("status kept", rd, {mPending, mShotOn});
		finishTest("apb errors");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/shotGameTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module shotGameTop (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,                              // from video timing
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic signed [gamePkg::coordWidth-1:0] shotX,   // to the drawing stage
	output logic signed [gamePkg::coordWidth-1:0] shotY,
	output logic shotActive,
	output logic signed [gamePkg::coordWidth-1:0] targetX,
	output logic signed [gamePkg::coordWidth-1:0] targetY,
	output logic hit
);

	logic fireReq;
	logic [1:0] fireDir;
	logic signed [gamePkg::coordWidth-1:0] fireX;
	logic fireTaken;
	logic signed [5:0] targetSpeed;
	logic [9:0] targetRow;
	logic [gamePkg::scoreWidth-1:0] score;

	objectIf shotBus ();
	objectIf targetBus ();

	apbRegs u_apbRegs (
		.clk(clk),
		.resetN(resetN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.fireReq(fireReq),
		.fireDir(fireDir),
		.fireX(fireX),
		.fireTaken(fireTaken),
		.targetSpeed(targetSpeed),
		.targetRow(targetRow),
		.score(score),
		.shotActive(shotBus.active)     // flag straight from the shot
	);

	shotLogic u_shotLogic (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.fireReq(fireReq),
		.fireDir(fireDir),
		.fireX(fireX),
		.fireTaken(fireTaken),
		.shot(shotBus.mover)
	);

	targetLogic u_targetLogic (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.targetSpeed(targetSpeed),
		.targetRow(targetRow),
		.target(targetBus.mover)
	);

	hitDetector u_hitDetector (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.shot(shotBus.observer),
		.target(targetBus.observer),
		.score(score)
	);

	assign shotX = shotBus.x;
	assign shotY = shotBus.y;
	assign shotActive = shotBus.active;
	assign targetX = targetBus.x;
	assign targetY = targetBus.y;
	assign hit = shotBus.collision;        // same level on both buses

endmodule

`default_nettype wire

// ==== design/hitDetector.sv ====
`timescale 1ns/10ps
`default_nettype none

module hitDetector (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	objectIf.observer shot,
	objectIf.observer target,
	output logic [gamePkg::scoreWidth-1:0] score
);

	logic signed [gamePkg::coordWidth:0] dx;   // wide enough for any difference
	logic signed [gamePkg::coordWidth:0] dy;
	logic [gamePkg::coordWidth:0] absDx;
	logic [gamePkg::coordWidth:0] absDy;
	logic hit;

	assign dx = shot.x - target.x;
	assign dy = shot.y - target.y;
	assign absDx = dx[gamePkg::coordWidth] ? -dx : dx;
	assign absDy = dy[gamePkg::coordWidth] ? -dy : dy;

	// equal sized boxes overlap when both distances are under one edge
	assign hit = shot.active && target.active &&
		(absDx < gamePkg::spriteSize) && (absDy < gamePkg::spriteSize);

	// both movers see the same event
	assign shot.collision = hit;
	assign target.collision = hit;

	// one point per frame with overlap, stops at all ones
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			score <= '0;
		else if (startOfFrame && hit && (score != '1))
			score <= score + 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/targetLogic.sv ====
`timescale 1ns/10ps
`default_nettype none

module targetLogic (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic signed [5:0] targetSpeed,     // host speed setting
	input logic [9:0] targetRow,
	objectIf.mover target
);

	logic signed [gamePkg::coordWidth-1:0] x;
	logic [9:0] row;
	logic signed [5:0] velocity;              // current heading and speed
	logic signed [5:0] speedSeen;             // targetSpeed at the last frame
	logic signed [5:0] stepVel;
	logic signed [gamePkg::coordWidth:0] nextX;   // one extra bit for the edge test

	// a new host speed replaces the bounced velocity
	assign stepVel = (targetSpeed != speedSeen) ? targetSpeed : velocity;
	assign nextX = x + stepVel;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			x <= '0;
			row <= gamePkg::targetStartRow;
			velocity <= gamePkg::targetStartSpeed;
			speedSeen <= gamePkg::targetStartSpeed;
		end else if (startOfFrame) begin
			row <= targetRow;
			speedSeen <= targetSpeed;
			if (target.collision) begin       // respawn at the left edge
				x <= '0;
				velocity <= targetSpeed;
			end else if (nextX < 0) begin
				x <= '0;
				velocity <= -stepVel;         // bounce off the left edge
			end else if (nextX > gamePkg::targetMaxX) begin
				x <= gamePkg::targetMaxX;
				velocity <= -stepVel;         // and off the right edge
			end else begin
				x <= nextX[gamePkg::coordWidth-1:0];
				velocity <= stepVel;
			end
		end
	end

	assign target.active = 1'b1;              // never parked
	assign target.x = x;
	assign target.y = {1'b0, row};

	// clamp keeps the whole box on screen
	xInRange: assert property (@(posedge clk) disable iff (!resetN)
		(x >= 0) && (x <= gamePkg::targetMaxX));

endmodule

`default_nettype wire

// ==== design/shotLogic.sv ====
`timescale 1ns/10ps
`default_nettype none

module shotLogic (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,                              // one update per frame
	input logic fireReq,
	input logic [1:0] fireDir,
	input logic signed [gamePkg::coordWidth-1:0] fireX,
	output logic fireTaken,
	objectIf.mover shot
);

	logic signed [gamePkg::fixedWidth-1:0] xFix;       // position, 1/64 pixel
	logic signed [gamePkg::fixedWidth-1:0] yFix;
	logic signed [gamePkg::fixedWidth-1:0] speedX;     // sideways step per frame
	logic signed [gamePkg::fixedWidth-1:0] fireXFix;
	logic active;
	logic done;

	// pixel column to fixed point, sign bit on top
	assign fireXFix = {fireX[gamePkg::coordWidth-1], fireX, {gamePkg::fixedShift{1'b0}}};

	// launch only from the parked state
	assign fireTaken = startOfFrame && !active && fireReq;

	// hit, or box fully above the screen
	assign done = shot.collision || (yFix <= gamePkg::topLimitFix);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xFix <= gamePkg::parkXFix;
			yFix <= gamePkg::parkYFix;
			speedX <= '0;
			active <= 1'b0;
		end else if (startOfFrame) begin
			if (done) begin                   // overrides deploy and move
				xFix <= gamePkg::parkXFix;
				yFix <= gamePkg::parkYFix;
				active <= 1'b0;
			end else if (fireTaken) begin
				xFix <= fireXFix;
				yFix <= gamePkg::launchYFix;
				active <= 1'b1;
				case (fireDir)
					2'd1: speedX <= gamePkg::stepX;    // right
					2'd2: speedX <= -gamePkg::stepX;   // left
					default: speedX <= '0;
				endcase
			end else if (active) begin
				xFix <= xFix + speedX;
				yFix <= yFix - gamePkg::stepY;     // y grows downward
			end
		end
	end

	// drop the fraction bits
	assign shot.active = active;
	assign shot.x = xFix[gamePkg::fixedShift +: gamePkg::coordWidth];
	assign shot.y = yFix[gamePkg::fixedShift +: gamePkg::coordWidth];

	// the shot only starts flying from an accepted fire command
	launchFromFire: assert property (@(posedge clk) disable iff (!resetN)
		$rose(active) |-> $past(fireTaken));

endmodule

`default_nettype wire

// ==== design/apbRegs.sv ====
`timescale 1ns/10ps
`default_nettype none

module apbRegs (
	input logic clk,
	input logic resetN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic fireReq,                                  // fire command pending
	output logic [1:0] fireDir,
	output logic signed [gamePkg::coordWidth-1:0] fireX,
	input logic fireTaken,                                 // shot deployed this edge
	output logic signed [5:0] targetSpeed,
	output logic [9:0] targetRow,
	input logic [gamePkg::scoreWidth-1:0] score,
	input logic shotActive
);

	gamePkg::cmdWord_t wrWord;       // pwdata in both layouts
	gamePkg::cmdWord_t fireView;     // readback of the fire register
	gamePkg::cmdWord_t targetView;
	logic setup;
	logic access;
	logic addrKnown;
	logic addrReadOnly;
	logic wrFire;
	logic wrTarget;
	logic [31:0] rdData;

	assign pready = 1'b1;            // zero wait states
	assign setup = psel && !penable;
	assign access = psel && penable;
	assign wrWord = pwdata;

	assign wrFire = access && pwrite && (paddr == gamePkg::addrFire);
	assign wrTarget = access && pwrite && (paddr == gamePkg::addrTarget);

	// address decode and read mux
	always_comb begin
		fireView = '0;
		fireView.fire.dir = fireDir;
		fireView.fire.initialX = fireX;
		targetView = '0;
		targetView.target.speed = targetSpeed;
		targetView.target.row = targetRow;
		rdData = '0;
		addrKnown = 1'b1;
		addrReadOnly = 1'b0;
		case (paddr)
			gamePkg::addrFire: rdData = fireView;
			gamePkg::addrTarget: rdData = targetView;
			gamePkg::addrScore: begin
				rdData = 32'(score);
				addrReadOnly = 1'b1;
			end
			gamePkg::addrStatus: begin
				rdData = {30'd0, fireReq, shotActive};
				addrReadOnly = 1'b1;
			end
			default: addrKnown = 1'b0;   // misaligned offsets
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			fireReq <= 1'b0;
			targetSpeed <= gamePkg::targetStartSpeed;
			targetRow <= gamePkg::targetStartRow;
			pslverr <= 1'b0;
			prdata <= '0;
		end else begin
			if (wrFire)
				fireReq <= 1'b1;          // a fresh write wins over the accept
			else if (fireTaken)
				fireReq <= 1'b0;
			if (wrTarget) begin
				targetSpeed <= wrWord.target.speed;   // picked up at next frame
				targetRow <= wrWord.target.row;
			end
			// response prepared in setup, held through the access cycle
			pslverr <= setup && (!addrKnown || (pwrite && addrReadOnly));
			if (setup)
				prdata <= rdData;
		end
	end

	// fire command payload
	always_ff @(posedge clk) begin
		if (wrFire) begin
			fireDir <= wrWord.fire.dir;
			fireX <= wrWord.fire.initialX;
		end
	end

	// error is only flagged while the master is in the access phase
	errOnlyInAccess: assert property (@(posedge clk) disable iff (!resetN)
		pslverr |-> psel && penable);

endmodule

`default_nettype wire

// ==== design/objectIf.sv ====
`timescale 1ns/10ps
`default_nettype none

// one moving object as seen by the hit detector
interface objectIf;

	logic active;                                  // low while parked off screen
	logic signed [gamePkg::coordWidth-1:0] x;      // top left corner, pixels
	logic signed [gamePkg::coordWidth-1:0] y;
	logic collision;                               // overlap level from the detector

	// the block that owns the position
	modport mover (
		output active,
		output x,
		output y,
		input collision
	);

	// the block that tests for overlap
	modport observer (
		input active,
		input x,
		input y,
		output collision
	);

endinterface

`default_nettype wire

// ==== design/gamePkg.sv ====
`default_nettype none

package gamePkg;

	// screen and sprite geometry in pixels
	localparam int screenWidth = 640;    // parking column of an inactive object
	localparam int screenHeight = 480;   // parking row
	localparam int spriteSize = 32;      // edge of both bounding boxes
	localparam int launchY = 415;        // shot start row

	localparam int coordWidth = 11;      // signed pixel coordinate
	localparam int fixedWidth = 18;      // signed fixed point position
	localparam int scoreWidth = 16;

	// target limits and power-up values
	localparam logic signed [coordWidth-1:0] targetMaxX = coordWidth'(screenWidth - spriteSize);
	localparam logic [9:0] targetStartRow = 10'd40;
	localparam logic signed [5:0] targetStartSpeed = 6'sd2;

	// fixed point, one pixel is 64 units
	localparam int fixedShift = 6;
	localparam int shotSpeedY = 150;     // upward, every frame
	localparam int shotSpeedX = 25;      // only for directions 1 and 2
	localparam logic signed [fixedWidth-1:0] stepX = fixedWidth'(shotSpeedX);
	localparam logic signed [fixedWidth-1:0] stepY = fixedWidth'(shotSpeedY);
	localparam logic signed [fixedWidth-1:0] parkXFix = fixedWidth'(screenWidth << fixedShift);
	localparam logic signed [fixedWidth-1:0] parkYFix = fixedWidth'(screenHeight << fixedShift);
	localparam logic signed [fixedWidth-1:0] launchYFix = fixedWidth'(launchY << fixedShift);
	// shot is gone once its box is fully above row 0
	localparam logic signed [fixedWidth-1:0] topLimitFix = fixedWidth'(-(spriteSize << fixedShift));

	// register map, byte addresses
	localparam logic [3:0] addrFire = 4'h0;
	localparam logic [3:0] addrTarget = 4'h4;
	localparam logic [3:0] addrScore = 4'h8;    // read only
	localparam logic [3:0] addrStatus = 4'hC;   // read only

	typedef struct packed {
		logic [31-2-coordWidth:0] pad;
		logic [1:0] dir;                      // 1 right, 2 left, else straight up
		logic signed [coordWidth-1:0] initialX;
	} fireCmd_t;

	typedef struct packed {
		logic [15:0] pad;
		logic signed [5:0] speed;             // pixels per frame, sign gives heading
		logic [9:0] row;
	} targetCmd_t;

	// one APB word, layout picked by the address
	typedef union packed {
		fireCmd_t fire;
		targetCmd_t target;
	} cmdWord_t;

endpackage

`default_nettype wire
